//--- logic/mem_pkg.sv
//////////////////////////////////////////////////
// Data memory geometry shared by the RTL and the testbench
// Four byte banks make up one 32-bit word
// SIZE encoding matches the core's two-bit size field
//////////////////////////////////////////////////

package mem_pkg;

    // Word width in bits
    parameter int DATA_WIDTH = 32;

    // One bank per byte lane
    parameter int NUM_BANKS  = 4;
    parameter int LANE_WIDTH = 2;

    typedef enum logic [1:0] {
        SIZE_NONE = 2'b00,
        SIZE_BYTE = 2'b01,
        SIZE_HALF = 2'b10,
        SIZE_WORD = 2'b11
    } access_size_e;

endpackage

//--- logic/lsu_pkg.sv
//////////////////////////////////////////////////
// Load/store opcodes and load/store unit states
// Bit 3 of an opcode marks a store, bit 2 a zero-extended load
// Encodings not listed are reserved and never touch memory
//////////////////////////////////////////////////

package lsu_pkg;

    typedef enum logic [3:0] {
        OP_LB  = 4'b0000,
        OP_LH  = 4'b0001,
        OP_LW  = 4'b0010,
        OP_LBU = 4'b0100,
        OP_LHU = 4'b0101,
        OP_SB  = 4'b1000,
        OP_SH  = 4'b1001,
        OP_SW  = 4'b1010
    } lsu_op_e;

    typedef enum logic [1:0] {
        ST_IDLE   = 2'b00,
        ST_ACCESS = 2'b01,
        ST_LOAD   = 2'b10,
        ST_ACK    = 2'b11
    } lsu_state_e;

endpackage

//--- logic/byte_bank.sv
//////////////////////////////////////////////////
// One byte-wide bank, 2**ROW_WIDTH rows
// Contents are not reset, only the read register
// Read returns old data when read and write hit one row
//////////////////////////////////////////////////

`timescale 1ns/100ps

module byte_bank #(
    parameter int ROW_WIDTH = 3
) (
    input  logic                 clk,
    input  logic                 i_rst,
    input  logic                 i_we,
    input  logic                 i_re,
    input  logic [ROW_WIDTH-1:0] i_waddr,
    input  logic [ROW_WIDTH-1:0] i_raddr,
    input  logic [7:0]           i_din,
    output logic [7:0]           o_dout
);

    logic [7:0] rows [2**ROW_WIDTH];

    always_ff @(posedge clk) begin
        if (i_we) begin
            rows[i_waddr] <= i_din;
        end
    end

    // Registered read, holds between read enables
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_dout <= 8'h00;
        end else if (i_re) begin
            o_dout <= rows[i_raddr];
        end
    end

endmodule

//--- logic/bank_steer.sv
//////////////////////////////////////////////////
// Bank enables, rows and lane selects for one access
// Any byte address works, banks below the start bank
// take the next row and the last row wraps to zero
//////////////////////////////////////////////////

`timescale 1ns/100ps

module bank_steer import mem_pkg::*; #(
    parameter int ADDR_WIDTH = 5
) (
    input  logic                                             i_wen,
    input  access_size_e                                     i_size,
    input  logic [ADDR_WIDTH-1:0]                            i_waddr,
    input  logic [ADDR_WIDTH-1:0]                            i_raddr,
    output logic [NUM_BANKS-1:0]                             o_bank_we,
    output logic [NUM_BANKS-1:0][ADDR_WIDTH-LANE_WIDTH-1:0] o_wrow,
    output logic [NUM_BANKS-1:0][ADDR_WIDTH-LANE_WIDTH-1:0] o_rrow,
    output logic [NUM_BANKS-1:0][LANE_WIDTH-1:0]            o_lane_sel
);

    localparam int ROW_WIDTH = ADDR_WIDTH - LANE_WIDTH;

    logic [LANE_WIDTH-1:0] wstart;
    logic [LANE_WIDTH-1:0] rstart;
    logic [ROW_WIDTH-1:0]  wrow_base;
    logic [ROW_WIDTH-1:0]  rrow_base;
    logic [LANE_WIDTH:0]   num_bytes;

    assign wstart    = i_waddr[LANE_WIDTH-1:0];
    assign rstart    = i_raddr[LANE_WIDTH-1:0];
    assign wrow_base = i_waddr[ADDR_WIDTH-1:LANE_WIDTH];
    assign rrow_base = i_raddr[ADDR_WIDTH-1:LANE_WIDTH];

    always_comb begin
        case (i_size)
            SIZE_BYTE: num_bytes = (LANE_WIDTH + 1)'(1);
            SIZE_HALF: num_bytes = (LANE_WIDTH + 1)'(2);
            SIZE_WORD: num_bytes = (LANE_WIDTH + 1)'(NUM_BANKS);
            default:   num_bytes = '0;
        endcase
    end

    // Lane select is the bank's distance from the start bank
    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            o_lane_sel[b] = LANE_WIDTH'(b) - wstart;
            o_bank_we[b]  = i_wen && ({1'b0, o_lane_sel[b]} < num_bytes);
            o_wrow[b]     = (LANE_WIDTH'(b) < wstart) ? wrow_base + 1'b1 : wrow_base;
            o_rrow[b]     = (LANE_WIDTH'(b) < rstart) ? rrow_base + 1'b1 : rrow_base;
        end
    end

    always_comb begin
        assert final (i_wen || o_bank_we == '0)
            else $error("bank write enable without i_wen");
    end

endmodule

//--- logic/data_memory.sv
//////////////////////////////////////////////////
// Byte-addressed data memory built from four banks
// Write in one cycle, read data valid the cycle after i_ren
// o_dout is zero whenever no read completed last cycle
// Memory contents are not reset or preloaded
//////////////////////////////////////////////////

`timescale 1ns/100ps

module data_memory import mem_pkg::*; #(
    parameter int ADDR_WIDTH = 5
) (
    input  logic                  clk,
    input  logic                  i_rst,
    input  logic                  i_wen,
    input  logic                  i_ren,
    input  access_size_e          i_size,
    input  logic [ADDR_WIDTH-1:0] i_waddr,
    input  logic [ADDR_WIDTH-1:0] i_raddr,
    input  logic [DATA_WIDTH-1:0] i_din,
    output logic [DATA_WIDTH-1:0] o_dout
);

    localparam int ROW_WIDTH = ADDR_WIDTH - LANE_WIDTH;

    logic [NUM_BANKS-1:0]                 bank_we;
    logic [NUM_BANKS-1:0][ROW_WIDTH-1:0]  bank_wrow;
    logic [NUM_BANKS-1:0][ROW_WIDTH-1:0]  bank_rrow;
    logic [NUM_BANKS-1:0][LANE_WIDTH-1:0] lane_sel;
    logic [NUM_BANKS-1:0][7:0]            bank_din;
    logic [NUM_BANKS-1:0][7:0]            bank_dout;

    logic                  rd_valid;
    logic [LANE_WIDTH-1:0] rstart_q;
    logic [DATA_WIDTH-1:0] rdata;

    bank_steer #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_bank_steer (
        .i_wen      (i_wen),
        .i_size     (i_size),
        .i_waddr    (i_waddr),
        .i_raddr    (i_raddr),
        .o_bank_we  (bank_we),
        .o_wrow     (bank_wrow),
        .o_rrow     (bank_rrow),
        .o_lane_sel (lane_sel)
    );

    // Each bank takes the data byte its lane select points at
    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            bank_din[b] = i_din[8*lane_sel[b] +: 8];
        end
    end

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        byte_bank #(
            .ROW_WIDTH (ROW_WIDTH)
        ) u_byte_bank (
            .clk     (clk),
            .i_rst   (i_rst),
            .i_we    (bank_we[b]),
            .i_re    (i_ren),
            .i_waddr (bank_wrow[b]),
            .i_raddr (bank_rrow[b]),
            .i_din   (bank_din[b]),
            .o_dout  (bank_dout[b])
        );
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= i_ren;
        end
    end

    // Start bank of the read in flight
    always_ff @(posedge clk) begin
        if (i_ren) begin
            rstart_q <= i_raddr[LANE_WIDTH-1:0];
        end
    end

    // Byte k of the result comes from bank start+k
    always_comb begin
        for (int k = 0; k < NUM_BANKS; k++) begin
            rdata[8*k +: 8] = bank_dout[LANE_WIDTH'(rstart_q + k)];
        end
    end

    assign o_dout = rd_valid ? rdata : '0;

    a_no_wr_rd_overlap: assert property (
        @(posedge clk) disable iff (i_rst) !(i_wen && i_ren)
    ) else $error("write and read requested in the same cycle");

endmodule

//--- logic/load_store_unit.sv
//////////////////////////////////////////////////
// Load/store unit with a four-phase req/ack handshake
// One request at a time, inputs held until o_ack
// Store acks 2 cycles after req is taken, load 3 cycles
// Reserved opcodes ack with zero and skip memory
//////////////////////////////////////////////////

`timescale 1ns/100ps

module load_store_unit import mem_pkg::*, lsu_pkg::*; #(
    parameter int ADDR_WIDTH = 5
) (
    input  logic                  clk,
    input  logic                  i_rst,
    input  logic                  i_req,
    input  lsu_op_e               i_op,
    input  logic [ADDR_WIDTH-1:0] i_addr,
    input  logic [DATA_WIDTH-1:0] i_wdata,
    input  logic [DATA_WIDTH-1:0] i_mem_rdata,
    output logic                  o_ack,
    output logic [DATA_WIDTH-1:0] o_rdata,
    output logic                  o_mem_wen,
    output logic                  o_mem_ren,
    output access_size_e          o_mem_size,
    output logic [ADDR_WIDTH-1:0] o_mem_addr,
    output logic [DATA_WIDTH-1:0] o_mem_wdata
);

    lsu_state_e            state;
    lsu_op_e               op_q;
    logic [ADDR_WIDTH-1:0] addr_q;
    logic [DATA_WIDTH-1:0] wdata_q;

    access_size_e acc_size;
    logic         op_is_load;
    logic         op_is_store;

    function automatic logic [DATA_WIDTH-1:0] extend_load(
        input lsu_op_e               op,
        input logic [DATA_WIDTH-1:0] raw
    );
        logic [DATA_WIDTH-1:0] res;
        case (op)
            OP_LB:   res = {{(DATA_WIDTH-8){raw[7]}}, raw[7:0]};
            OP_LH:   res = {{(DATA_WIDTH-16){raw[15]}}, raw[15:0]};
            OP_LBU:  res = {{(DATA_WIDTH-8){1'b0}}, raw[7:0]};
            OP_LHU:  res = {{(DATA_WIDTH-16){1'b0}}, raw[15:0]};
            OP_LW:   res = raw;
            default: res = '0;
        endcase
        return res;
    endfunction

    // Opcode decode
    always_comb begin
        case (op_q)
            OP_LB, OP_LBU, OP_SB: acc_size = SIZE_BYTE;
            OP_LH, OP_LHU, OP_SH: acc_size = SIZE_HALF;
            OP_LW, OP_SW:         acc_size = SIZE_WORD;
            default:              acc_size = SIZE_NONE;
        endcase
    end

    assign op_is_load  = op_q inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
    assign op_is_store = op_q inside {OP_SB, OP_SH, OP_SW};

    // Request is latched when taken
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && i_req) begin
            op_q    <= i_op;
            addr_q  <= i_addr;
            wdata_q <= i_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state <= ST_IDLE;
            o_ack <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_req) begin
                        state <= ST_ACCESS;
                    end
                end
                ST_ACCESS: begin
                    state <= op_is_load ? ST_LOAD : ST_ACK;
                end
                ST_LOAD: begin
                    state <= ST_ACK;
                end
                ST_ACK: begin
                    // Ack holds until the requester drops req
                    if (o_ack && !i_req) begin
                        o_ack <= 1'b0;
                        state <= ST_IDLE;
                    end else begin
                        o_ack <= 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Stores and reserved opcodes return zero
    always_ff @(posedge clk) begin
        if (state == ST_ACCESS) begin
            o_rdata <= '0;
        end else if (state == ST_LOAD) begin
            o_rdata <= extend_load(op_q, i_mem_rdata);
        end
    end

    assign o_mem_wen   = (state == ST_ACCESS) && op_is_store;
    assign o_mem_ren   = (state == ST_ACCESS) && op_is_load;
    assign o_mem_size  = (o_mem_wen || o_mem_ren) ? acc_size : SIZE_NONE;
    assign o_mem_addr  = addr_q;
    assign o_mem_wdata = wdata_q;

    a_no_ack_in_idle: assert property (
        @(posedge clk) disable iff (i_rst) state == ST_IDLE |-> !o_ack
    ) else $error("o_ack high in ST_IDLE");

endmodule

//--- logic/dmem_top.sv
//////////////////////////////////////////////////
// Load/store unit in front of the byte-banked data memory
// ADDR_WIDTH is the byte-address width, at least 3
//////////////////////////////////////////////////

`timescale 1ns/100ps

module dmem_top import mem_pkg::*, lsu_pkg::*; #(
    parameter int ADDR_WIDTH = 5
) (
    input  logic                  clk,
    input  logic                  i_rst,
    input  logic                  i_req,
    input  lsu_op_e               i_op,
    input  logic [ADDR_WIDTH-1:0] i_addr,
    input  logic [DATA_WIDTH-1:0] i_wdata,
    output logic                  o_ack,
    output logic [DATA_WIDTH-1:0] o_rdata
);

    logic                  mem_wen;
    logic                  mem_ren;
    access_size_e          mem_size;
    logic [ADDR_WIDTH-1:0] mem_addr;
    logic [DATA_WIDTH-1:0] mem_wdata;
    logic [DATA_WIDTH-1:0] mem_rdata;

    load_store_unit #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_load_store_unit (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_req       (i_req),
        .i_op        (i_op),
        .i_addr      (i_addr),
        .i_wdata     (i_wdata),
        .i_mem_rdata (mem_rdata),
        .o_ack       (o_ack),
        .o_rdata     (o_rdata),
        .o_mem_wen   (mem_wen),
        .o_mem_ren   (mem_ren),
        .o_mem_size  (mem_size),
        .o_mem_addr  (mem_addr),
        .o_mem_wdata (mem_wdata)
    );

    // Same address serves both ports
    data_memory #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_data_memory (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_wen   (mem_wen),
        .i_ren   (mem_ren),
        .i_size  (mem_size),
        .i_waddr (mem_addr),
        .i_raddr (mem_addr),
        .i_din   (mem_wdata),
        .o_dout  (mem_rdata)
    );

endmodule

//--- dv/tb_dmem_model.svh
//////////////////////////////////////////////////
// Byte-array model of the data memory, compare tasks
// Included inside tb_dmem_top, uses its ADDR_WIDTH
//////////////////////////////////////////////////

`ifndef TB_DMEM_MODEL_SVH
`define TB_DMEM_MODEL_SVH

logic [7:0] model_mem [MEM_BYTES];

function automatic int access_bytes(input lsu_op_e op);
    case (op)
        OP_LB, OP_LBU, OP_SB: return 1;
        OP_LH, OP_LHU, OP_SH: return 2;
        OP_LW, OP_SW:         return 4;
        default:              return 0;
    endcase
endfunction

// Stores update the model, loads return the extended data
function automatic logic [DATA_WIDTH-1:0] model_apply(
    input lsu_op_e               op,
    input logic [ADDR_WIDTH-1:0] addr,
    input logic [DATA_WIDTH-1:0] wdata
);
    logic [DATA_WIDTH-1:0]        raw;
    logic signed [DATA_WIDTH-1:0] ext;
    logic signed [7:0]            sbyte;
    logic signed [15:0]           shalf;
    int                           idx;
    raw = '0;
    for (int k = 0; k < access_bytes(op); k++) begin
        idx = (int'(addr) + k) % MEM_BYTES;
        if (op inside {OP_SB, OP_SH, OP_SW}) begin
            model_mem[idx] = wdata[8*k +: 8];
        end else begin
            raw[8*k +: 8] = model_mem[idx];
        end
    end
    sbyte = raw[7:0];
    shalf = raw[15:0];
    if (op == OP_LB) begin
        ext = DATA_WIDTH'(sbyte);
    end else if (op == OP_LH) begin
        ext = DATA_WIDTH'(shalf);
    end else begin
        ext = raw;
    end
    return ext;
endfunction

task automatic check_data(
    input string                 name,
    input logic [DATA_WIDTH-1:0] expected,
    input logic [DATA_WIDTH-1:0] actual
);
    if (actual !== expected) begin
        abort_run($sformatf("MISMATCH %s: expected %h, actual %h", name, expected, actual));
    end
endtask

task automatic check_ack(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        abort_run($sformatf("MISMATCH %s: expected ack %b, actual %b", name, expected, actual));
    end
endtask

`endif

//--- dv/tb_dmem_top.sv
//////////////////////////////////////////////////
// Testbench for dmem_top at ADDR_WIDTH 6
// Memory starts unknown, so the fill test runs first
// Stops at the first error
//////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_dmem_top import mem_pkg::*, lsu_pkg::*; ();

    localparam int ADDR_WIDTH     = 6;
    localparam int MEM_BYTES      = 2**ADDR_WIDTH;
    localparam int NUM_WORDS      = MEM_BYTES / 4;
    localparam int RESET_CYCLES   = 16;
    localparam int NUM_RANDOM     = 300;
    localparam int NUM_PARTIAL    = 20;
    localparam int NUM_RESERVED   = 8;
    localparam int NUM_HOLD       = 20;
    localparam int NUM_REQUESTS   = 2*NUM_WORDS + NUM_RANDOM + 4*NUM_PARTIAL
                                    + 2*NUM_RESERVED + NUM_HOLD;
    localparam int TIMEOUT_CYCLES = NUM_REQUESTS*8 + 100;
    localparam int ACK_WAIT       = 8;

    localparam lsu_op_e VALID_OPS [8] = '{OP_LB, OP_LH, OP_LW, OP_LBU,
                                          OP_LHU, OP_SB, OP_SH, OP_SW};
    localparam logic [3:0] RESERVED_CODES [8] = '{4'd3, 4'd6, 4'd7, 4'd11,
                                                  4'd12, 4'd13, 4'd14, 4'd15};

    logic                  clk = 1'b0;
    logic                  i_rst;
    logic                  i_req;
    lsu_op_e               i_op;
    logic [ADDR_WIDTH-1:0] i_addr;
    logic [DATA_WIDTH-1:0] i_wdata;
    logic                  o_ack;
    logic [DATA_WIDTH-1:0] o_rdata;
    int                    cycle_count = 0;
    bit                    traffic_started = 1'b0;

    dmem_top #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_dmem_top (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_req   (i_req),
        .i_op    (i_op),
        .i_addr  (i_addr),
        .i_wdata (i_wdata),
        .o_ack   (o_ack),
        .o_rdata (o_rdata)
    );

    always #20 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped");
    endtask

`include "tb_dmem_model.svh"

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout after %0d cycles", cycle_count));
        end
    end

    // Ack must stay low through reset and until the first request
    always @(negedge clk) begin
        if (!traffic_started) begin
            check_ack("reset_state", 1'b0, o_ack);
        end
    end

    // One full four-phase handshake, hold adds cycles with req still high
    task automatic do_access(
        input string                 name,
        input lsu_op_e               op,
        input logic [ADDR_WIDTH-1:0] addr,
        input logic [DATA_WIDTH-1:0] wdata,
        input int                    hold
    );
        logic [DATA_WIDTH-1:0] expected;
        bit                    has_data;
        int                    waited;
        expected = model_apply(op, addr, wdata);
        has_data = !(op inside {OP_SB, OP_SH, OP_SW});
        @(posedge clk);
        i_req   <= 1'b1;
        i_op    <= op;
        i_addr  <= addr;
        i_wdata <= wdata;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > ACK_WAIT) begin
                abort_run($sformatf("%s: no ack within %0d cycles", name, ACK_WAIT));
            end
        end while (!o_ack);
        if (has_data) begin
            check_data(name, expected, o_rdata);
        end
        repeat (hold) begin
            @(negedge clk);
            check_ack(name, 1'b1, o_ack);
            if (has_data) begin
                check_data(name, expected, o_rdata);
            end
        end
        @(posedge clk);
        i_req <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > ACK_WAIT) begin
                abort_run($sformatf("%s: ack did not fall after req dropped", name));
            end
        end while (o_ack);
    endtask

    initial begin
        logic [ADDR_WIDTH-1:0] addr;
        logic [ADDR_WIDTH-1:0] base;
        lsu_op_e               op;
        void'($urandom(32'hb5a6));
        i_rst   = 1'b1;
        i_req   = 1'b0;
        i_op    = OP_LW;
        i_addr  = '0;
        i_wdata = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        i_rst <= 1'b0;
        repeat (3) @(posedge clk);
        traffic_started = 1'b1;

        for (int w = 0; w < NUM_WORDS; w++) begin
            do_access("fill_store", OP_SW, ADDR_WIDTH'(4*w), $urandom(), 0);
        end
        for (int w = 0; w < NUM_WORDS; w++) begin
            do_access("fill_load", OP_LW, ADDR_WIDTH'(4*w), '0, 0);
        end

        for (int n = 0; n < NUM_RANDOM; n++) begin
            op = VALID_OPS[$urandom_range(0, 7)];
            do_access("random_mixed", op, ADDR_WIDTH'($urandom()), $urandom(), 0);
        end

        // Neighbor words catch stray byte enables and wrap errors
        for (int n = 0; n < NUM_PARTIAL; n++) begin
            addr = ADDR_WIDTH'($urandom());
            op   = ($urandom_range(0, 1) == 1) ? OP_SH : OP_SB;
            base = {addr[ADDR_WIDTH-1:2], 2'b00};
            do_access("partial_store", op, addr, $urandom(), 0);
            do_access("partial_word", OP_LW, base, '0, 0);
            do_access("partial_below", OP_LW, base - ADDR_WIDTH'(4), '0, 0);
            do_access("partial_above", OP_LW, base + ADDR_WIDTH'(4), '0, 0);
        end

        for (int n = 0; n < NUM_RESERVED; n++) begin
            addr = ADDR_WIDTH'($urandom());
            op   = lsu_op_e'(RESERVED_CODES[$urandom_range(0, 7)]);
            do_access("reserved_op", op, addr, $urandom(), 0);
            do_access("reserved_after", OP_LW, {addr[ADDR_WIDTH-1:2], 2'b00}, '0, 0);
        end

        for (int n = 0; n < NUM_HOLD; n++) begin
            op = VALID_OPS[$urandom_range(0, 7)];
            do_access("backpressure", op, ADDR_WIDTH'($urandom()), $urandom(),
                      int'($urandom_range(0, 5)));
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+dv
logic/mem_pkg.sv
logic/lsu_pkg.sv
logic/byte_bank.sv
logic/bank_steer.sv
logic/data_memory.sv
logic/load_store_unit.sv
logic/dmem_top.sv
dv/tb_dmem_top.sv

//--- run_sim.sh
#!/bin/sh
# Builds tb_dmem_top with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_dmem_top -Mdir "$OBJ" -f verilog.f
if [ $? -ne 0 ]; then
    echo "Compile failed"
    exit 1
fi

"./$OBJ/Vtb_dmem_top" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "FAIL: see errors above" "$LOG"; then
    echo "Simulation reported errors"
    exit 1
fi
if [ "$run_status" -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
if ! grep -q "PASS: all tests" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0
